/* common/sys_pkg.sv */
package sys_pkg;

  // register map, selected by wb_adr_i[4:1].
  typedef enum logic [3:0] {
    REG_BOARD_ID    = 4'd0,
    REG_REV_MAJOR   = 4'd1,
    REG_REV_MINOR   = 4'd2,
    REG_REV_RCS     = 4'd3,
    REG_SCRATCHPAD  = 4'd4,
    REG_FIFO_D3     = 4'd5, // debug word bits 63:48.
    REG_FIFO_D2     = 4'd6,
    REG_FIFO_D1     = 4'd7,
    REG_FIFO_D0     = 4'd8, // debug word bits 15:0.
    REG_FIFO_STATUS = 4'd9
  } reg_addr_e;

  // the last member sits at bit 0 of the status word.
  typedef struct packed {
    logic empty;
    logic almost_empty;
    logic full;
    logic almost_full;
  } fifo_status_t;

  localparam logic [15:0] BOARD_ID  = 16'hdead;
  localparam logic [15:0] REV_MAJOR = 16'haaaa;
  localparam logic [15:0] REV_MINOR = 16'hbbbb;
  localparam logic [15:0] REV_RCS   = 16'hcccc;

  localparam int DEBUG_WIDTH = 64;

  localparam int FIFO_DEPTH_LOG2 = 4;
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  localparam int FIFO_PTR_W      = FIFO_DEPTH_LOG2 + 1; // one extra bit tells full from empty.
  localparam int FIFO_ALMOST_GAP = 2;

  typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;

  // fill thresholds for the status flags.
  localparam fifo_ptr_t FIFO_FULL_CNT   = fifo_ptr_t'(FIFO_DEPTH);
  localparam fifo_ptr_t FIFO_AFULL_CNT  = fifo_ptr_t'(FIFO_DEPTH - FIFO_ALMOST_GAP);
  localparam fifo_ptr_t FIFO_AEMPTY_CNT = fifo_ptr_t'(FIFO_ALMOST_GAP - 1);

endpackage

/* common/debug_rd_if.sv */
interface debug_rd_if;

  logic                             rd_en;  // pops the head on a wb_clk_i edge.
  logic [sys_pkg::DEBUG_WIDTH-1:0]  dout;   // head entry, valid while not empty.
  sys_pkg::fifo_status_t            status;

  modport fifo_side (
    input  rd_en,
    output dout,
    output status
  );

  modport regs_side (
    output rd_en,
    input  dout,
    input  status
  );

endinterface

/* debug_fifo/debug_fifo.sv */
module debug_fifo (
  input  logic                            wb_clk_i,
  input  logic                            wb_rst_i,
  input  logic                            debug_clk_i,
  input  logic                            debug_we_i,
  input  logic [sys_pkg::DEBUG_WIDTH-1:0] debug_i,
  debug_rd_if.fifo_side                   rd_port
);

  logic [sys_pkg::DEBUG_WIDTH-1:0] mem [sys_pkg::FIFO_DEPTH];

  // write domain.
  logic                wr_rst_meta;
  logic                wr_rst;
  sys_pkg::fifo_ptr_t  wr_bin;
  sys_pkg::fifo_ptr_t  wr_bin_next;
  sys_pkg::fifo_ptr_t  wr_gray;
  sys_pkg::fifo_ptr_t  rd_gray_w1;
  sys_pkg::fifo_ptr_t  rd_gray_w2;
  logic                wr_full;
  logic                wr_push;

  // read domain.
  sys_pkg::fifo_ptr_t  rd_bin;
  sys_pkg::fifo_ptr_t  rd_bin_next;
  sys_pkg::fifo_ptr_t  rd_gray;
  sys_pkg::fifo_ptr_t  wr_gray_r1;
  sys_pkg::fifo_ptr_t  wr_gray_r2;
  sys_pkg::fifo_ptr_t  wr_bin_r;
  sys_pkg::fifo_ptr_t  fill_cnt;
  logic                rd_pop;

  function automatic sys_pkg::fifo_ptr_t bin2gray(input sys_pkg::fifo_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic sys_pkg::fifo_ptr_t gray2bin(input sys_pkg::fifo_ptr_t gray);
    sys_pkg::fifo_ptr_t bin;
    bin[sys_pkg::FIFO_PTR_W-1] = gray[sys_pkg::FIFO_PTR_W-1];
    for (int i = sys_pkg::FIFO_PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  // wb_rst_i crosses into the debug domain through two flops.
  always_ff @(posedge debug_clk_i) begin
    wr_rst_meta <= wb_rst_i;
    wr_rst      <= wr_rst_meta;
  end

  // read pointer into the write domain.
  always_ff @(posedge debug_clk_i) begin
    if (wr_rst) begin
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      rd_gray_w1 <= rd_gray;
      rd_gray_w2 <= rd_gray_w1;
    end
  end

  // full when the pointers differ only in their two top bits, in Gray code.
  assign wr_full = (wr_gray == {~rd_gray_w2[sys_pkg::FIFO_PTR_W-1 -: 2],
                                rd_gray_w2[sys_pkg::FIFO_PTR_W-3:0]});

  assign wr_push     = debug_we_i & ~wr_full; // writes into a full FIFO are lost.
  assign wr_bin_next = wr_bin + 1'b1;

  always_ff @(posedge debug_clk_i) begin
    if (wr_rst) begin
      wr_bin  <= '0;
      wr_gray <= '0;
    end else if (wr_push) begin
      wr_bin  <= wr_bin_next;
      wr_gray <= bin2gray(wr_bin_next);
    end
  end

  always_ff @(posedge debug_clk_i) begin
    if (wr_push) begin
      mem[wr_bin[sys_pkg::FIFO_DEPTH_LOG2-1:0]] <= debug_i;
    end
  end

  // write pointer into the read domain.
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      wr_gray_r1 <= wr_gray;
      wr_gray_r2 <= wr_gray_r1;
    end
  end

  assign wr_bin_r = gray2bin(wr_gray_r2);
  assign fill_cnt = wr_bin_r - rd_bin;

  assign rd_port.status.empty        = (fill_cnt == '0);
  assign rd_port.status.almost_empty = (fill_cnt <= sys_pkg::FIFO_AEMPTY_CNT);
  assign rd_port.status.full         = (fill_cnt == sys_pkg::FIFO_FULL_CNT);
  assign rd_port.status.almost_full  = (fill_cnt >= sys_pkg::FIFO_AFULL_CNT);

  assign rd_pop      = rd_port.rd_en & ~rd_port.status.empty; // pops of an empty FIFO are ignored.
  assign rd_bin_next = rd_bin + 1'b1;

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rd_bin  <= '0;
      rd_gray <= '0;
    end else if (rd_pop) begin
      rd_bin  <= rd_bin_next;
      rd_gray <= bin2gray(rd_bin_next);
    end
  end

  // first word fall through, the head is always on dout.
  assign rd_port.dout = mem[rd_bin[sys_pkg::FIFO_DEPTH_LOG2-1:0]];

endmodule

/* source/sys_regs.sv */
module sys_regs (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  debug_rd_if.regs_side rd_port
);

  sys_pkg::reg_addr_e acc_addr;
  sys_pkg::reg_addr_e dat_sel;
  logic               accept;
  logic               scratch_we;
  logic [15:0]        scratch_pad;
  logic               fifo_rd_en;

  // addresses past the map decode to values outside the enum and read zero.
  assign acc_addr = sys_pkg::reg_addr_e'(wb_adr_i[4:1]);

  // the ack cycle itself never accepts, so accesses are two cycles apart.
  assign accept = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  assign scratch_we = accept & wb_we_i & (acc_addr == sys_pkg::REG_SCRATCHPAD);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      fifo_rd_en <= 1'b0;
    end else begin
      wb_ack_o   <= accept;
      // writes to the status address pop as well.
      fifo_rd_en <= accept & (acc_addr == sys_pkg::REG_FIFO_STATUS);
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      dat_sel <= acc_addr; // held for the readback during the ack cycle.
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      scratch_pad <= '0;
    end else if (scratch_we) begin
      if (wb_sel_i[0]) begin
        scratch_pad[7:0] <= wb_dat_i[7:0];
      end
      if (wb_sel_i[1]) begin
        scratch_pad[15:8] <= wb_dat_i[15:8];
      end
    end
  end

  // the status word shows the FIFO before the pop that the same read causes.
  always_comb begin
    case (dat_sel)
      sys_pkg::REG_BOARD_ID: begin
        wb_dat_o = sys_pkg::BOARD_ID;
      end
      sys_pkg::REG_REV_MAJOR: begin
        wb_dat_o = sys_pkg::REV_MAJOR;
      end
      sys_pkg::REG_REV_MINOR: begin
        wb_dat_o = sys_pkg::REV_MINOR;
      end
      sys_pkg::REG_REV_RCS: begin
        wb_dat_o = sys_pkg::REV_RCS;
      end
      sys_pkg::REG_SCRATCHPAD: begin
        wb_dat_o = scratch_pad;
      end
      sys_pkg::REG_FIFO_D3: begin
        wb_dat_o = rd_port.dout[63:48];
      end
      sys_pkg::REG_FIFO_D2: begin
        wb_dat_o = rd_port.dout[47:32];
      end
      sys_pkg::REG_FIFO_D1: begin
        wb_dat_o = rd_port.dout[31:16];
      end
      sys_pkg::REG_FIFO_D0: begin
        wb_dat_o = rd_port.dout[15:0];
      end
      sys_pkg::REG_FIFO_STATUS: begin
        wb_dat_o = {12'b0, rd_port.status};
      end
      default: begin
        wb_dat_o = '0;
      end
    endcase
  end

  assign rd_port.rd_en = fifo_rd_en; // one cycle, in step with the ack.

endmodule

/* source/sys_block.sv */
module sys_block (
  input  logic                            wb_clk_i,
  input  logic                            wb_rst_i,
  input  logic                            wb_cyc_i,
  input  logic                            wb_stb_i,
  input  logic                            wb_we_i,
  input  logic [1:0]                      wb_sel_i,
  input  logic [31:0]                     wb_adr_i,
  input  logic [15:0]                     wb_dat_i,
  output logic [15:0]                     wb_dat_o,
  output logic                            wb_ack_o,
  input  logic                            debug_clk_i,
  input  logic                            debug_we_i,
  input  logic [sys_pkg::DEBUG_WIDTH-1:0] debug_i
);

  debug_rd_if rd_bus ();

  // bus side, runs on wb_clk_i.
  sys_regs u_regs (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_sel_i (wb_sel_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .rd_port  (rd_bus.regs_side)
  );

  // debug capture, written on debug_clk_i and read on wb_clk_i.
  debug_fifo u_fifo (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .debug_clk_i (debug_clk_i),
    .debug_we_i  (debug_we_i),
    .debug_i     (debug_i),
    .rd_port     (rd_bus.fifo_side)
  );

endmodule

/* bench/sys_regs_assert.sv */
module sys_regs_assert (
  input logic wb_clk_i,
  input logic wb_rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic rd_en
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  ack_single_cycle: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) wb_ack_o |=> !wb_ack_o
  ) else begin
    $error("acknowledge stayed high for two cycles");
    fail_count++;
  end

  ack_after_strobe: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i)
  ) else begin
    $error("acknowledge rose without a preceding cycle and strobe");
    fail_count++;
  end

  pop_with_ack: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) rd_en |-> wb_ack_o
  ) else begin
    $error("FIFO read enable without an acknowledge");
    fail_count++;
  end

  // reset clears ack at the same edge, so the next sample sees it low.
  ack_low_after_reset: assert property (
    @(posedge wb_clk_i) $past(wb_rst_i) |-> !wb_ack_o
  ) else begin
    $error("acknowledge high in the cycle after reset");
    fail_count++;
  end

endmodule

bind sys_regs sys_regs_assert u_bus_assert (
  .wb_clk_i (wb_clk_i),
  .wb_rst_i (wb_rst_i),
  .wb_cyc_i (wb_cyc_i),
  .wb_stb_i (wb_stb_i),
  .wb_ack_o (wb_ack_o),
  .rd_en    (fifo_rd_en)
);

/* bench/tb_sys_block.sv */
module tb_sys_block;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WB_HALF      = 2;
  localparam int DEBUG_HALF   = 3;
  localparam int FIFO_ENTRIES = 1 << sys_pkg::FIFO_DEPTH_LOG2;
  localparam int SYNC_CYCLES  = 10;    // longer than both pointer synchronizers together.
  localparam int WATCHDOG_NS  = 20000; // about ten times the length of all tests.

  logic                            wb_clk_i;
  logic                            wb_rst_i;
  logic                            wb_cyc_i;
  logic                            wb_stb_i;
  logic                            wb_we_i;
  logic [1:0]                      wb_sel_i;
  logic [31:0]                     wb_adr_i;
  logic [15:0]                     wb_dat_i;
  logic [15:0]                     wb_dat_o;
  logic                            wb_ack_o;
  logic                            debug_clk_i;
  logic                            debug_we_i;
  logic [sys_pkg::DEBUG_WIDTH-1:0] debug_i;

  integer                          seed;
  logic [sys_pkg::DEBUG_WIDTH-1:0] model_q [$]; // entries the FIFO should hold, head first.

  sys_block DUT (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_sel_i    (wb_sel_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .debug_clk_i (debug_clk_i),
    .debug_we_i  (debug_we_i),
    .debug_i     (debug_i)
  );

  initial begin
    wb_clk_i = 1'b0;
    forever #(WB_HALF) wb_clk_i = ~wb_clk_i;
  end

  initial begin
    debug_clk_i = 1'b0;
    forever #(DEBUG_HALF) debug_clk_i = ~debug_clk_i;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // flags print as empty, almost_empty, full, almost_full.
  task automatic check_status(input string name, input sys_pkg::fifo_status_t exp,
                              input sys_pkg::fifo_status_t act);
    if (act !== exp) begin
      abort_run($sformatf("FAIL %s: expected status %b, actual status %b", name, exp, act));
    end
  endtask

  function automatic sys_pkg::fifo_status_t status_for_count(input int count);
    sys_pkg::fifo_status_t st;
    st.empty        = (count == 0);
    st.almost_empty = (count <= sys_pkg::FIFO_ALMOST_GAP - 1);
    st.full         = (count == FIFO_ENTRIES);
    st.almost_full  = (count >= FIFO_ENTRIES - sys_pkg::FIFO_ALMOST_GAP);
    return st;
  endfunction

  task automatic wait_sync();
    repeat (SYNC_CYCLES) @(negedge wb_clk_i);
  endtask

  // one Wishbone access, held until the slave acknowledges one cycle later.
  task automatic wb_cycle(input logic [3:0] index, input logic we, input logic [15:0] wdata,
                          input logic [1:0] sel, output logic [15:0] rdata);
    @(negedge wb_clk_i);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = {27'b0, index, 1'b0};
    wb_dat_i = wdata;
    @(negedge wb_clk_i);
    if (!wb_ack_o) begin
      abort_run("the Wishbone slave did not acknowledge one cycle after the strobe");
    end else begin
      rdata    = wb_dat_o;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
    end
  endtask

  task automatic wb_read(input logic [3:0] index, output logic [15:0] rdata);
    wb_cycle(index, 1'b0, 16'h0000, 2'b11, rdata);
  endtask

  task automatic wb_write(input logic [3:0] index, input logic [15:0] wdata,
                          input logic [1:0] sel);
    logic [15:0] unused;
    wb_cycle(index, 1'b1, wdata, sel, unused);
  endtask

  // random entries; the model drops what a full FIFO would drop.
  task automatic debug_push(input int count);
    logic [sys_pkg::DEBUG_WIDTH-1:0] word;
    wait_sync();
    for (int i = 0; i < count; i++) begin
      word = {$random(seed), $random(seed)};
      @(negedge debug_clk_i);
      debug_we_i = 1'b1;
      debug_i    = word;
      if (model_q.size() < FIFO_ENTRIES) begin
        model_q.push_back(word);
      end
    end
    @(negedge debug_clk_i);
    debug_we_i = 1'b0;
    wait_sync();
  endtask

  task automatic read_status(input string name, input int count);
    logic [15:0] rdata;
    wb_read(sys_pkg::REG_FIFO_STATUS, rdata);
    check_status(name, status_for_count(count), sys_pkg::fifo_status_t'(rdata[3:0]));
    check_word(name, 16'h0000, rdata & 16'hfff0);
  endtask

  // the status read at the end pops the head.
  task automatic pop_and_check(input string name);
    logic [15:0]                     rdata;
    logic [sys_pkg::DEBUG_WIDTH-1:0] head;
    head = model_q[0];
    wb_read(sys_pkg::REG_FIFO_D3, rdata);
    check_word(name, head[63:48], rdata);
    wb_read(sys_pkg::REG_FIFO_D2, rdata);
    check_word(name, head[47:32], rdata);
    wb_read(sys_pkg::REG_FIFO_D1, rdata);
    check_word(name, head[31:16], rdata);
    wb_read(sys_pkg::REG_FIFO_D0, rdata);
    check_word(name, head[15:0], rdata);
    read_status(name, model_q.size());
    void'(model_q.pop_front());
  endtask

  task automatic id_words();
    logic [15:0] rdata;
    wb_read(sys_pkg::REG_BOARD_ID, rdata);
    check_word("id_regs", sys_pkg::BOARD_ID, rdata);
    wb_read(sys_pkg::REG_REV_MAJOR, rdata);
    check_word("id_regs", sys_pkg::REV_MAJOR, rdata);
    wb_read(sys_pkg::REG_REV_MINOR, rdata);
    check_word("id_regs", sys_pkg::REV_MINOR, rdata);
    wb_read(sys_pkg::REG_REV_RCS, rdata);
    check_word("id_regs", sys_pkg::REV_RCS, rdata);
    wb_read(4'hf, rdata); // outside the register map.
    check_word("id_regs", 16'h0000, rdata);
    read_status("id_regs", 0);
  endtask

  task automatic scratch_lanes();
    logic [15:0] rdata;
    logic [15:0] expect_pad;
    expect_pad = 16'h0000;
    wb_read(sys_pkg::REG_SCRATCHPAD, rdata);
    check_word("scratchpad", expect_pad, rdata);
    wb_write(sys_pkg::REG_SCRATCHPAD, 16'ha5c3, 2'b11);
    expect_pad = 16'ha5c3;
    wb_read(sys_pkg::REG_SCRATCHPAD, rdata);
    check_word("scratchpad", expect_pad, rdata);
    wb_write(sys_pkg::REG_SCRATCHPAD, 16'h1234, 2'b01);
    expect_pad[7:0] = 8'h34;
    wb_read(sys_pkg::REG_SCRATCHPAD, rdata);
    check_word("scratchpad", expect_pad, rdata);
    wb_write(sys_pkg::REG_SCRATCHPAD, 16'h5678, 2'b10);
    expect_pad[15:8] = 8'h56;
    wb_read(sys_pkg::REG_SCRATCHPAD, rdata);
    check_word("scratchpad", expect_pad, rdata);
  endtask

  task automatic entry_order();
    debug_push(5);
    repeat (5) pop_and_check("fifo_order");
    read_status("fifo_order", 0);
  endtask

  // each status read also pops, so the fill is topped up before the full check.
  task automatic flag_levels();
    debug_push(FIFO_ENTRIES - sys_pkg::FIFO_ALMOST_GAP);
    pop_and_check("fifo_flags");
    debug_push(FIFO_ENTRIES - model_q.size());
    pop_and_check("fifo_flags");
  endtask

  task automatic overflow_drop();
    debug_push(FIFO_ENTRIES - model_q.size());
    debug_push(4); // all four are dropped.
    repeat (FIFO_ENTRIES) pop_and_check("fifo_overflow");
    read_status("fifo_overflow", 0);
    read_status("fifo_overflow", 0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run($sformatf("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS));
  end

  initial begin
    seed       = 32'h3c48_fb53;
    wb_rst_i   = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_sel_i   = 2'b00;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    debug_we_i = 1'b0;
    debug_i    = '0;
    repeat (3) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    wait_sync(); // lets the write-domain reset synchronizer release.
    id_words();
    scratch_lanes();
    entry_order();
    flag_levels();
    overflow_drop();
    if (DUT.u_regs.u_bus_assert.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      abort_run("a bus protocol assertion on the register block failed");
    end
  end

endmodule

/* files.f */
common/sys_pkg.sv
common/debug_rd_if.sv
debug_fifo/debug_fifo.sv
source/sys_regs.sv
source/sys_block.sv
bench/sys_regs_assert.sv
bench/tb_sys_block.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sys_block
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# the binary exits with a failing status on $fatal or a failed assertion.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
